// File: rtl/exec_pkg.sv
package exec_pkg;

  // ========================================
  // Widths and latencies
  // ========================================
  localparam int XLEN        = 32;
  localparam int MUL_LATENCY = 2;
  localparam int DIV_STEPS   = 32;
  localparam int DIV_CNT_W   = $clog2(DIV_STEPS);
  localparam int PROD_W      = 2 * XLEN;

  // ========================================
  // Opcodes
  // ========================================
  // ALU group sits below CALC_OP_MUL
  typedef enum logic [3:0] {
    CALC_OP_ADD  = 4'd0,
    CALC_OP_SUB  = 4'd1,
    CALC_OP_SLT  = 4'd2,
    CALC_OP_AND  = 4'd3,
    CALC_OP_OR   = 4'd4,
    CALC_OP_XOR  = 4'd5,
    CALC_OP_NOR  = 4'd6,
    CALC_OP_SL   = 4'd7,
    CALC_OP_SR   = 4'd8,
    CALC_OP_LUI  = 4'd9,
    CALC_OP_MUL  = 4'd10,
    CALC_OP_MULH = 4'd11,
    CALC_OP_DIV  = 4'd12,
    CALC_OP_MOD  = 4'd13
  } calc_op_e;

  // Request from issue
  typedef struct packed {
    calc_op_e        op;
    logic [XLEN-1:0] src0;
    logic [XLEN-1:0] src1;
    logic            is_unsigned;
  } exec_req_t;

  // Multiply/divide result, tagged with its opcode
  typedef struct packed {
    logic            valid;
    calc_op_e        op;
    logic [XLEN-1:0] result;
  } mdu_rsp_t;

  function automatic logic is_alu_op(calc_op_e op);
    return op < CALC_OP_MUL;
  endfunction

  function automatic logic is_mul_op(calc_op_e op);
    return (op == CALC_OP_MUL) || (op == CALC_OP_MULH);
  endfunction

  function automatic logic is_div_op(calc_op_e op);
    return (op == CALC_OP_DIV) || (op == CALC_OP_MOD);
  endfunction

endpackage

// File: rtl/alu_core.sv
`timescale 1ns/10ps

module alu_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  exec_pkg::exec_req_t       req_i,
  output logic [exec_pkg::XLEN-1:0] res_o
);

  localparam int W       = exec_pkg::XLEN;
  localparam int SHAMT_W = $clog2(W);

  logic [W-1:0]       src0;
  logic [W-1:0]       src1;
  logic [SHAMT_W-1:0] shamt;
  logic               less_than;
  logic [W-1:0]       alu_d;

  assign src0  = req_i.src0;
  assign src1  = req_i.src1;
  // Only the low bits of src1 count as shift amount
  assign shamt = src1[SHAMT_W-1:0];

  // Compare for SLT
  always_comb begin
    if (req_i.is_unsigned) begin
      less_than = src0 < src1;
    end else begin
      less_than = $signed(src0) < $signed(src1);
    end
  end

  // ========================================
  // Function select
  // ========================================
  always_comb begin
    case (req_i.op)
      exec_pkg::CALC_OP_ADD: begin
        alu_d = src0 + src1;
      end
      exec_pkg::CALC_OP_SUB: begin
        alu_d = src0 - src1;
      end
      exec_pkg::CALC_OP_SLT: begin
        alu_d = {{(W-1){1'b0}}, less_than};
      end
      exec_pkg::CALC_OP_AND: begin
        alu_d = src0 & src1;
      end
      exec_pkg::CALC_OP_OR: begin
        alu_d = src0 | src1;
      end
      exec_pkg::CALC_OP_XOR: begin
        alu_d = src0 ^ src1;
      end
      exec_pkg::CALC_OP_NOR: begin
        alu_d = ~(src0 | src1);
      end
      exec_pkg::CALC_OP_SL: begin
        alu_d = src0 << shamt;
      end
      exec_pkg::CALC_OP_SR: begin
        if (req_i.is_unsigned) begin
          alu_d = src0 >> shamt;
        end else begin
          alu_d = $unsigned($signed(src0) >>> shamt);
        end
      end
      exec_pkg::CALC_OP_LUI: begin
        alu_d = src1;
      end
      // Multiply and divide produce nothing here
      default: begin
        alu_d = '0;
      end
    endcase
  end

  // Result holds until the next start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_o <= '0;
    end else if (start_i) begin
      res_o <= alu_d;
    end
  end

endmodule

// File: rtl/div_unit.sv
`timescale 1ns/10ps

module div_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  logic                      start_i,
  input  logic [exec_pkg::XLEN-1:0] dividend_i,
  input  logic [exec_pkg::XLEN-1:0] divisor_i,
  input  logic                      signed_i,
  output logic                      done_o,
  output logic [exec_pkg::XLEN-1:0] quotient_o,
  output logic [exec_pkg::XLEN-1:0] remainder_o,
  output logic                      busy_o
);

  localparam int W  = exec_pkg::XLEN;
  localparam int CW = exec_pkg::DIV_CNT_W;
  localparam logic [CW-1:0] LAST_STEP = CW'(exec_pkg::DIV_STEPS - 1);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FIX
  } div_state_e;

  div_state_e    state_q;
  logic [CW-1:0] cnt_q;
  logic [W-1:0]  quo_q;
  logic [W-1:0]  rem_q;
  logic [W-1:0]  dvs_q;
  logic [W-1:0]  dividend_q;
  logic          neg_quo_q;
  logic          neg_rem_q;
  logic          div_zero_q;
  logic          overflow_q;
  logic          dividend_neg;
  logic          divisor_neg;
  logic [W-1:0]  dividend_mag;
  logic [W-1:0]  divisor_mag;
  logic [W:0]    shifted;
  logic [W:0]    trial;
  logic          quo_bit;
  logic [W-1:0]  rem_next;

  // Operand magnitudes
  assign dividend_neg = signed_i & dividend_i[W-1];
  assign divisor_neg  = signed_i & divisor_i[W-1];
  assign dividend_mag = dividend_neg ? -dividend_i : dividend_i;
  assign divisor_mag  = divisor_neg ? -divisor_i : divisor_i;

  // One restoring step: shift in the next dividend bit, try to subtract
  assign shifted  = {rem_q, quo_q[W-1]};
  assign trial    = shifted - {1'b0, dvs_q};
  assign quo_bit  = shifted >= {1'b0, dvs_q};
  assign rem_next = quo_bit ? trial[W-1:0] : shifted[W-1:0];

  // ========================================
  // FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= RUN;
            cnt_q   <= '0;
          end
        end
        RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST_STEP) begin
            state_q <= FIX;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Datapath, loaded at start and shifted while running
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && start_i) begin
      quo_q      <= dividend_mag;
      rem_q      <= '0;
      dvs_q      <= divisor_mag;
      dividend_q <= dividend_i;
      neg_quo_q  <= dividend_neg ^ divisor_neg;
      neg_rem_q  <= dividend_neg;
      div_zero_q <= divisor_i == '0;
      overflow_q <= signed_i && (dividend_i == {1'b1, {(W-1){1'b0}}}) && (divisor_i == '1);
    end else if (state_q == RUN) begin
      quo_q <= {quo_q[W-2:0], quo_bit};
      rem_q <= rem_next;
    end
  end

  // Sign fix-up and special cases, seen in the FIX cycle
  always_comb begin
    if (div_zero_q) begin
      quotient_o  = '1;
      remainder_o = dividend_q;
    end else if (overflow_q) begin
      quotient_o  = dividend_q;
      remainder_o = '0;
    end else begin
      quotient_o  = neg_quo_q ? -quo_q : quo_q;
      remainder_o = neg_rem_q ? -rem_q : rem_q;
    end
  end

  assign done_o = state_q == FIX;
  assign busy_o = state_q != IDLE;

endmodule

// File: rtl/mul_div_unit.sv
`timescale 1ns/10ps

module mul_div_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,
  input  logic                accept_i,
  input  exec_pkg::exec_req_t req_i,
  output exec_pkg::mdu_rsp_t  rsp_o,
  output logic                div_busy_o
);

  localparam int W  = exec_pkg::XLEN;
  localparam int PW = exec_pkg::PROD_W;

  logic               mul_start;
  logic               div_start;
  logic               ext_a;
  logic               ext_b;
  logic               mul_s1_valid_q;
  exec_pkg::calc_op_e mul_s1_op_q;
  logic signed [W:0]  mul_a_q;
  logic signed [W:0]  mul_b_q;
  logic signed [2*W+1:0] prod_full;
  logic               mul_s2_valid_q;
  exec_pkg::calc_op_e mul_s2_op_q;
  logic [PW-1:0]      prod_q;
  exec_pkg::calc_op_e div_op_q;
  logic               div_done;
  logic [W-1:0]       div_quo;
  logic [W-1:0]       div_rem;

  assign mul_start = accept_i & ~flush_i & exec_pkg::is_mul_op(req_i.op);
  assign div_start = accept_i & ~flush_i & exec_pkg::is_div_op(req_i.op);

  // Extension bit, sign or zero
  assign ext_a = ~req_i.is_unsigned & req_i.src0[W-1];
  assign ext_b = ~req_i.is_unsigned & req_i.src1[W-1];

  // ========================================
  // Two-stage multiplier
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mul_s1_valid_q <= 1'b0;
      mul_s2_valid_q <= 1'b0;
    end else if (flush_i) begin
      mul_s1_valid_q <= 1'b0;
      mul_s2_valid_q <= 1'b0;
    end else begin
      mul_s1_valid_q <= mul_start;
      mul_s2_valid_q <= mul_s1_valid_q;
    end
  end

  assign prod_full = mul_a_q * mul_b_q;

  always_ff @(posedge clk) begin
    if (mul_start) begin
      mul_a_q     <= {ext_a, req_i.src0};
      mul_b_q     <= {ext_b, req_i.src1};
      mul_s1_op_q <= req_i.op;
    end
    if (mul_s1_valid_q) begin
      prod_q      <= prod_full[PW-1:0];
      mul_s2_op_q <= mul_s1_op_q;
    end
    // Remember whether quotient or remainder is wanted
    if (div_start) begin
      div_op_q <= req_i.op;
    end
  end

  div_unit u_div_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .start_i     (div_start),
    .dividend_i  (req_i.src0),
    .divisor_i   (req_i.src1),
    .signed_i    (~req_i.is_unsigned),
    .done_o      (div_done),
    .quotient_o  (div_quo),
    .remainder_o (div_rem),
    .busy_o      (div_busy_o)
  );

  // Divider and multiplier never finish together, issue keeps them apart
  always_comb begin
    if (div_done) begin
      rsp_o.valid  = 1'b1;
      rsp_o.op     = div_op_q;
      rsp_o.result = (div_op_q == exec_pkg::CALC_OP_MOD) ? div_rem : div_quo;
    end else begin
      rsp_o.valid  = mul_s2_valid_q;
      rsp_o.op     = mul_s2_op_q;
      rsp_o.result = (mul_s2_op_q == exec_pkg::CALC_OP_MULH) ? prod_q[PW-1:W] : prod_q[W-1:0];
    end
  end

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/10ps

module exec_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  logic                      valid_i,
  input  exec_pkg::exec_req_t       req_i,
  output logic                      ready_o,
  output logic                      valid_o,
  output logic [exec_pkg::XLEN-1:0] res_o
);

  localparam int W     = exec_pkg::XLEN;
  localparam int DEPTH = exec_pkg::MUL_LATENCY;

  logic               accept;
  logic               pipe_load;
  logic               pipe_busy;
  logic               div_req;
  logic               div_busy;
  logic [DEPTH-1:0]   slot_valid_q;
  exec_pkg::calc_op_e slot_op_q [DEPTH];
  logic [W-1:0]       alu_res;
  logic [W-1:0]       alu_dly_q;
  exec_pkg::mdu_rsp_t mdu_rsp;
  logic               last_is_alu;

  // ========================================
  // Issue control
  // ========================================
  assign div_req   = exec_pkg::is_div_op(req_i.op);
  assign pipe_busy = |slot_valid_q;

  // A divide waits for the fixed-latency pipe to drain
  assign ready_o   = ~div_busy & ~(div_req & pipe_busy);
  assign accept    = valid_i & ready_o;

  // Only ALU and multiply ops enter the pipe
  assign pipe_load = accept & ~flush_i & ~div_req;

  alu_core u_alu_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (accept),
    .req_i   (req_i),
    .res_o   (alu_res)
  );

  mul_div_unit u_mul_div_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .accept_i   (accept),
    .req_i      (req_i),
    .rsp_o      (mdu_rsp),
    .div_busy_o (div_busy)
  );

  // ========================================
  // In-flight slots
  // ========================================
  // Slot 0 is newest, slot DEPTH-1 retires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= '0;
    end else if (flush_i) begin
      slot_valid_q <= '0;
    end else begin
      slot_valid_q <= {slot_valid_q[DEPTH-2:0], pipe_load};
    end
  end

  always_ff @(posedge clk) begin
    slot_op_q[0] <= req_i.op;
    for (int i = 1; i < DEPTH; i++) begin
      slot_op_q[i] <= slot_op_q[i-1];
    end
    // Extra stage lines the ALU up with the multiplier
    if (slot_valid_q[0]) begin
      alu_dly_q <= alu_res;
    end
  end

  // ========================================
  // Result select
  // ========================================
  assign last_is_alu = slot_valid_q[DEPTH-1] & exec_pkg::is_alu_op(slot_op_q[DEPTH-1]);

  // Nothing retires in a flush cycle
  assign valid_o = ~flush_i & (slot_valid_q[DEPTH-1] | mdu_rsp.valid);
  assign res_o   = last_is_alu ? alu_dly_q : mdu_rsp.result;

endmodule

// File: sim/exec_properties.sv
`timescale 1ns/10ps

module exec_properties (
  input logic clk,
  input logic rst_n,
  input logic flush_i,
  input logic valid_i,
  input logic ready_i,
  input logic res_valid_i,
  input logic div_req_i,
  input logic div_busy_i,
  input logic slot_new_i
);

  int fail_count = 0;

  no_result_in_reset: assert property (@(posedge clk) !rst_n |-> !res_valid_i)
    else begin
      fail_count++;
      $error("valid_o high while reset is held");
    end

  idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> ready_i && !res_valid_i)
    else begin
      fail_count++;
      $error("exec unit not idle after reset");
    end

  // Issue stalls from the divide accept until its result shows
  stall_while_dividing: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    (valid_i && ready_i && div_req_i) || (div_busy_i && !res_valid_i) |=> !ready_i)
    else begin
      fail_count++;
      $error("ready_o high while the divider is busy");
    end

  // A stalled request must not reach the pipe or the divider
  accept_needs_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i |=> !slot_new_i && !$rose(div_busy_i))
    else begin
      fail_count++;
      $error("operation accepted while ready_o low");
    end

endmodule

bind exec_unit exec_properties u_exec_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush_i     (flush_i),
  .valid_i     (valid_i),
  .ready_i     (ready_o),
  .res_valid_i (valid_o),
  .div_req_i   (div_req),
  .div_busy_i  (div_busy),
  .slot_new_i  (slot_valid_q[0])
);

// File: sim/exec_checker.sv
`timescale 1ns/10ps

module exec_checker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  input  logic                      valid_i,
  input  exec_pkg::exec_req_t       req_i,
  input  logic                      ready_i,
  input  logic                      res_valid_i,
  input  logic [exec_pkg::XLEN-1:0] res_i,
  output int                        error_count_o,
  output int                        checked_o,
  output int                        pending_o
);

  typedef struct packed {
    exec_pkg::calc_op_e op;
    logic               is_unsigned;
    logic [31:0]        value;
    int                 accept_cycle;
  } expect_t;

  expect_t expect_q[$];
  int      cycle;
  logic    reset_seen;

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [31:0] model_result(exec_pkg::exec_req_t r);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] prod;
    // Sources widened by sign or zero, so one signed rule covers both
    xa   = {{32{~r.is_unsigned & r.src0[31]}}, r.src0};
    xb   = {{32{~r.is_unsigned & r.src1[31]}}, r.src1};
    prod = xa * xb;
    case (r.op)
      exec_pkg::CALC_OP_ADD:  return r.src0 + r.src1;
      exec_pkg::CALC_OP_SUB:  return r.src0 - r.src1;
      exec_pkg::CALC_OP_SLT:  return {31'b0, $signed(xa) < $signed(xb)};
      exec_pkg::CALC_OP_AND:  return r.src0 & r.src1;
      exec_pkg::CALC_OP_OR:   return r.src0 | r.src1;
      exec_pkg::CALC_OP_XOR:  return r.src0 ^ r.src1;
      exec_pkg::CALC_OP_NOR:  return ~(r.src0 | r.src1);
      exec_pkg::CALC_OP_SL:   return r.src0 << r.src1[4:0];
      exec_pkg::CALC_OP_SR:   return 32'(xa >> r.src1[4:0]);
      exec_pkg::CALC_OP_LUI:  return r.src1;
      exec_pkg::CALC_OP_MUL:  return prod[31:0];
      exec_pkg::CALC_OP_MULH: return prod[63:32];
      // 64-bit quotient of the overflow case wraps back to the dividend
      exec_pkg::CALC_OP_DIV:  return (r.src1 == '0) ? '1 : 32'($signed(xa) / $signed(xb));
      exec_pkg::CALC_OP_MOD:  return (r.src1 == '0) ? r.src0 : 32'($signed(xa) % $signed(xb));
      default:                return '0;
    endcase
  endfunction

  function automatic string test_name(expect_t e);
    exec_pkg::calc_op_e op;
    op = e.op;
    return $sformatf("%s %s", op.name(), e.is_unsigned ? "unsigned" : "signed");
  endfunction

  always @(posedge clk) begin
    expect_t e;
    int      want_lat;
    cycle++;
    if (!rst_n) begin
      expect_q.delete();
      reset_seen = 1'b0;
    end else begin
      if (!reset_seen && (!ready_i || res_valid_i)) begin
        error_count_o++;
        $display("ready_o low or valid_o high in the first cycle after reset");
      end
      reset_seen = 1'b1;
      if (flush_i) begin
        if (res_valid_i) begin
          error_count_o++;
          $display("valid_o high in a flush cycle at cycle %0d", cycle);
        end
        // An op accepted together with the flush is dropped too
        expect_q.delete();
      end else begin
        if (res_valid_i) begin
          if (expect_q.size() == 0) begin
            error_count_o++;
            $display("valid_o high with no operation outstanding at cycle %0d", cycle);
          end else begin
            e = expect_q.pop_front();
            checked_o++;
            if (res_i !== e.value) begin
              error_count_o++;
              $display("error %s: expected %h, actual %h", test_name(e), e.value, res_i);
            end
            if (e.op == exec_pkg::CALC_OP_DIV || e.op == exec_pkg::CALC_OP_MOD) begin
              want_lat = exec_pkg::DIV_STEPS + 1;
            end else begin
              want_lat = exec_pkg::MUL_LATENCY;
            end
            if (cycle - e.accept_cycle != want_lat) begin
              error_count_o++;
              $display("error %s latency: expected %0d, actual %0d",
                       test_name(e), want_lat, cycle - e.accept_cycle);
            end
          end
        end
        if (valid_i && ready_i) begin
          e.op           = req_i.op;
          e.is_unsigned  = req_i.is_unsigned;
          e.value        = model_result(req_i);
          e.accept_cycle = cycle;
          expect_q.push_back(e);
        end
      end
    end
    pending_o = expect_q.size();
  end

endmodule

// File: sim/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;

  localparam int NUM_OPS    = 2000;
  localparam int MAX_CYCLES = 40;
  localparam int CLK_PERIOD = 10;

  logic                clk;
  logic                rst_n;
  logic                flush;
  logic                valid;
  exec_pkg::exec_req_t req;
  logic                ready;
  logic                res_valid;
  logic [31:0]         res;
  int                  error_count;
  int                  checked;
  int                  pending;

  exec_unit uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush),
    .valid_i (valid),
    .req_i   (req),
    .ready_o (ready),
    .valid_o (res_valid),
    .res_o   (res)
  );

  exec_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush),
    .valid_i       (valid),
    .req_i         (req),
    .ready_i       (ready),
    .res_valid_i   (res_valid),
    .res_i         (res),
    .error_count_o (error_count),
    .checked_o     (checked),
    .pending_o     (pending)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Corner values show up often enough to hit the special cases
  function automatic logic [31:0] pick_operand();
    case ($urandom_range(0, 9))
      0: return '0;
      1: return '1;
      2: return 32'h8000_0000;
      3: return $urandom_range(0, 31);
      default: return $urandom();
    endcase
  endfunction

  function automatic exec_pkg::exec_req_t make_request();
    exec_pkg::exec_req_t r;
    r.op          = exec_pkg::calc_op_e'(4'($urandom_range(0, 13)));
    r.src0        = pick_operand();
    r.src1        = pick_operand();
    r.is_unsigned = 1'($urandom_range(0, 1));
    // Most negative over minus one
    if ((r.op == exec_pkg::CALC_OP_DIV || r.op == exec_pkg::CALC_OP_MOD) &&
        $urandom_range(0, 5) == 0) begin
      r.src0 = 32'h8000_0000;
      r.src1 = '1;
    end
    return r;
  endfunction

  // Called at a falling edge, returns at the falling edge after the accept
  task automatic issue_op(input exec_pkg::exec_req_t op_req);
    logic accepted;
    valid = 1'b1;
    req   = op_req;
    flush = ($urandom_range(0, 63) == 0);
    @(posedge clk);
    accepted = ready;
    while (!accepted) begin
      @(negedge clk);
      flush = ($urandom_range(0, 127) == 0);
      @(posedge clk);
      accepted = ready;
    end
    @(negedge clk);
    valid = 1'b0;
    flush = 1'b0;
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int total_errors;
    void'($urandom(32'h7ec1_1739));
    rst_n = 1'b0;
    flush = 1'b0;
    valid = 1'b0;
    req   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < NUM_OPS; n++) begin
      issue_op(make_request());
      if ($urandom_range(0, 3) == 0) begin
        repeat ($urandom_range(1, 3)) @(negedge clk);
      end
    end
    while (pending != 0) @(negedge clk);
    // Stray results from dropped ops would show up here
    repeat (exec_pkg::DIV_STEPS + 4) @(posedge clk);
    total_errors = error_count + uut.u_exec_properties.fail_count;
    $display("results checked: %0d, errors: %0d", checked, total_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_OPS * MAX_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d ns", NUM_OPS * MAX_CYCLES * CLK_PERIOD);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: exec_unit.f
rtl/exec_pkg.sv
rtl/alu_core.sv
rtl/div_unit.sv
rtl/mul_div_unit.sv
rtl/exec_unit.sv
sim/exec_properties.sv
sim/exec_checker.sv
sim/exec_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module exec_tb \
  -f exec_unit.f \
  --Mdir obj_dir -o exec_sim

./obj_dir/exec_sim 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
